/* Makefile */
# Verilator simulation of the threshold unit
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module thresholdUnitTb \
		-Mdir obj_dir -f files.f
	./obj_dir/VthresholdUnitTb | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* files.f */
rtl/thresholdPkg.sv
rtl/thresholdLoader.sv
rtl/thresholdSearch.sv
rtl/thresholdUnit.sv
verif/thresholdUnit_checker.sv
verif/thresholdUnitTb.sv

/* rtl/thresholdLoader.sv */
// Threshold load sequencer, one command per cycle, no handshake
// Writes reach the search memories one cycle after cfgValid
// cfgError is sticky until reset; a rejected write stores nothing
`timescale 1ns/1ps

module thresholdLoader import thresholdPkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cfgValid,   // Single-cycle strobe
  input  cfgCmd_t                cfgCmd,
  output thrWrite_t              thrWr,
  output logic [numChannels-1:0] cfgDone,    // Channel holds a full set
  output logic                   cfgError
);

  // Per-channel sequence state
  logic [idxBits-1:0]       nextIdx [numChannels];  // Next load index, 1 based
  logic signed [inBits-1:0] lastVal [numChannels];  // Last accepted threshold

  // Selected channel view
  logic [idxBits-1:0]       curIdx;
  logic signed [inBits-1:0] prevVal;
  logic [outBits-1:0]       nodeAddr;

  logic isStart;
  logic isWrite;
  logic outOfRange;
  logic notAscending;
  logic badWrite;
  logic goodWrite;

  // Registered write port
  logic                     wrEn;
  logic [addrBits-1:0]      wrAddr;
  logic signed [inBits-1:0] wrData;

  assign curIdx = nextIdx[cfgCmd.cnl];
  assign prevVal = lastVal[cfgCmd.cnl];
  assign nodeAddr = outBits'(curIdx - 1'b1);       // Index i lives at node i-1

  assign isStart = cfgValid && (cfgCmd.op == opStart);
  assign isWrite = cfgValid && (cfgCmd.op == opWrite);

  // Sixteenth write has no node left
  assign outOfRange = curIdx > idxBits'(numThresholds);
  // First threshold of a sequence has nothing to compare with
  assign notAscending = (curIdx != idxBits'(1)) && (cfgCmd.value <= prevVal);

  assign badWrite = isWrite && (outOfRange || notAscending);
  assign goodWrite = isWrite && !badWrite;

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int c = 0; c < numChannels; c++) begin
        nextIdx[c] <= idxBits'(1);
      end
      cfgDone <= '0;
      cfgError <= 1'b0;
      wrEn <= 1'b0;
    end else begin
      wrEn <= goodWrite;                           // Lands one cycle later
      if (badWrite) begin
        cfgError <= 1'b1;                          // Sticky
      end
      if (isStart) begin
        nextIdx[cfgCmd.cnl] <= idxBits'(1);
        cfgDone[cfgCmd.cnl] <= 1'b0;               // Set is incomplete again
      end
      if (goodWrite) begin
        nextIdx[cfgCmd.cnl] <= curIdx + 1'b1;
        if (curIdx == idxBits'(numThresholds)) begin
          cfgDone[cfgCmd.cnl] <= 1'b1;             // Fifteenth threshold stored
        end
      end
    end
  end

  // Payload, qualified by wrEn and by the index counter
  always_ff @(posedge clk) begin
    if (goodWrite) begin
      lastVal[cfgCmd.cnl] <= cfgCmd.value;
    end
    wrAddr <= {cfgCmd.cnl, nodeAddr};
    wrData <= cfgCmd.value;
  end

  assign thrWr = '{we: wrEn, addr: wrAddr, data: wrData};

endmodule

/* rtl/thresholdPkg.sv */
// Widths, bias and shared types for the multi-threshold activation unit
// Samples and thresholds are signed; results are the count plus a fixed bias
// Thresholds per channel must be loaded lowest first, strictly ascending
package thresholdPkg;

  localparam int outBits = 4;            // Result precision, also the pipeline depth
  localparam int inBits = 8;             // Sample and threshold precision, signed
  localparam int numChannels = 4;        // Threshold sets
  localparam int cnlBits = 2;            // Channel number width
  localparam int numThresholds = 15;     // 2**outBits - 1 per channel
  localparam int outBias = -8;           // Added to the raw count
  localparam int resBits = 4;            // Signed result width, holds -8..7

  // Memory write address is channel over node index
  localparam int addrBits = cnlBits + outBits;
  // Load index counter runs 1..16, 16 meaning the set is full
  localparam int idxBits = 5;

  // Configuration opcodes
  typedef enum logic {
    opStart = 1'b0,                      // Restart a channel's load sequence
    opWrite = 1'b1                       // Store the channel's next threshold
  } cfgOp_e;

  typedef struct packed {
    cfgOp_e                   op;
    logic [cnlBits-1:0]       cnl;
    logic signed [inBits-1:0] value;     // Threshold value for opWrite
  } cfgCmd_t;

  // One write into the search memories
  typedef struct packed {
    logic                     we;
    logic [addrBits-1:0]      addr;      // {channel, node index}
    logic signed [inBits-1:0] data;
  } thrWrite_t;

  // Input stream item
  typedef struct packed {
    logic                     vld;
    logic [cnlBits-1:0]       cnl;
    logic signed [inBits-1:0] data;
  } sample_t;

  // Output stream item
  typedef struct packed {
    logic                      vld;
    logic [cnlBits-1:0]        cnl;
    logic signed [resBits-1:0] data;     // Count plus outBias
  } result_t;

endpackage

/* rtl/thresholdSearch.sv */
// Binary-search threshold pipeline, one stage per result bit
// run is the clock enable of every stage and read register
// Results are meaningful only for fully loaded channels
`timescale 1ns/1ps

module thresholdSearch import thresholdPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  thrWrite_t thrWr,   // From the loader, write side only
  input  logic      run,     // Pipeline clock enable
  input  sample_t   in,
  output result_t   out
);

  // Item travelling down the pipeline
  typedef struct packed {
    logic                     vld;
    logic [cnlBits-1:0]       cnl;
    logic signed [inBits-1:0] val;   // Original sample
    logic [outBits-1:0]       res;   // MSB first, stage s settles bit outBits-1-s
  } stage_t;

  // pipe[s] feeds stage s, pipe[outBits] is the finished item
  stage_t pipe [outBits+1];

  // Stage select from the node address suffix
  // The lowest zero bit of the node address picks the owning stage
  logic [outBits-1:0] nodeAddr;
  logic [outBits-1:0] wrSel;

  assign nodeAddr = thrWr.addr[outBits-1:0];
  assign wrSel = (nodeAddr + 1'b1) & ~nodeAddr;   // One hot, bit k means stage outBits-1-k

  // Feed, result bits start cleared
  assign pipe[0] = '{
    vld: in.vld,
    cnl: in.cnl,
    val: in.data,
    res: '0
  };

  for (genvar s = 0; s < outBits; s++) begin : genStage

    // Stage s holds 2**s nodes per channel
    logic signed [inBits-1:0] thrMem [numChannels << s];

    logic                     stageWe;
    logic [cnlBits+s-1:0]     wrAddr;    // Channel plus top s node address bits
    logic [addrBits-1:0]      rdFull;
    logic [cnlBits+s-1:0]     rdAddr;    // Channel plus result prefix
    logic signed [inBits-1:0] thrReg;    // Threshold read for the held sample
    stage_t                   stg;       // Held sample
    stage_t                   nxt;
    logic                     hit;

    // Write side
    assign stageWe = thrWr.we && wrSel[outBits-1-s];
    assign wrAddr = thrWr.addr[addrBits-1 -: cnlBits+s];

    always_ff @(posedge clk) begin
      if (stageWe) begin
        thrMem[wrAddr] <= thrWr.data;
      end
    end

    // Read side
    // Prefix bits above this stage are settled, lower ones are still zero
    assign rdFull = {pipe[s].cnl, pipe[s].res};
    assign rdAddr = rdFull[addrBits-1 -: cnlBits+s];

    always_ff @(posedge clk) begin
      if (run) begin
        thrReg <= thrMem[rdAddr];        // Old data on a same-cycle write
      end
    end

    // Stage register, only the valid bit is reset
    always_ff @(posedge clk) begin
      if (run) begin
        stg <= pipe[s];
      end
      if (rst) begin
        stg.vld <= 1'b0;
      end
    end

    // Signed compare, threshold not larger than sample
    assign hit = thrReg <= stg.val;

    // Patch in this stage's result bit
    always_comb begin
      nxt = stg;
      nxt.res[outBits-1-s] = hit;
    end

    assign pipe[s+1] = nxt;

  end : genStage

  // Output, count offset by the bias
  assign out.vld = pipe[outBits].vld;
  assign out.cnl = pipe[outBits].cnl;
  assign out.data = resBits'(int'(pipe[outBits].res) + outBias);  // Wraps into -8..7

endmodule

/* rtl/thresholdUnit.sv */
// Multi-threshold activation unit, loader in front of the search pipeline
// Loading may overlap streaming; results need the channel's cfgDone high
`timescale 1ns/1ps

module thresholdUnit import thresholdPkg::*; (
  input  logic                   clk,
  input  logic                   rst,

  // Threshold configuration
  input  logic                   cfgValid,   // Qualifies cfgCmd for one cycle
  input  cfgCmd_t                cfgCmd,

  // Stream
  input  logic                   run,        // Stalls the whole pipeline when low
  input  sample_t                in,
  output result_t                out,

  // Status
  output logic [numChannels-1:0] cfgDone,    // Per channel, full set loaded
  output logic                   cfgError    // Sticky order or overflow error
);

  // Memory write from loader to search
  thrWrite_t thrWr;

  // Sequences indices, builds addresses, checks order
  thresholdLoader loader (
    .clk      (clk),
    .rst      (rst),
    .cfgValid (cfgValid),
    .cfgCmd   (cfgCmd),
    .thrWr    (thrWr),
    .cfgDone  (cfgDone),
    .cfgError (cfgError)
  );

  // Four stage binary search
  thresholdSearch search (
    .clk   (clk),
    .rst   (rst),
    .thrWr (thrWr),
    .run   (run),
    .in    (in),
    .out   (out)
  );

endmodule

/* verif/thresholdUnitTb.sv */
// Self-checking testbench for the threshold unit with a fixed random seed
// Inputs change and outputs are compared on the falling edge
// A result counts as delivered at a rising edge with run high
`timescale 1ns/1ps

module thresholdUnitTb import thresholdPkg::*; ();

  logic                   clk;
  logic                   rst;
  logic                   cfgValid;
  cfgCmd_t                cfgCmd;
  logic                   run;
  sample_t                in;
  result_t                out;
  logic [numChannels-1:0] cfgDone;
  logic                   cfgError;

  // Reference model
  int                     thrModel [numChannels][numThresholds];  // Lowest first
  logic [numChannels-1:0] loadedMask;   // Channels holding a full set
  result_t                expQ [$];     // Results in flight, oldest first
  int                     sentCount;    // Enabled valid inputs
  int                     recvCount;    // Delivered outputs
  int                     cycleCount;
  integer                 seed;
  string                  testName;

  thresholdUnit dut (
    .clk      (clk),
    .rst      (rst),
    .cfgValid (cfgValid),
    .cfgCmd   (cfgCmd),
    .run      (run),
    .in       (in),
    .out      (out),
    .cfgDone  (cfgDone),
    .cfgError (cfgError)
  );

  always #20 clk = ~clk;                // 40 ns period

  // Run limit of about twice the stimulus length
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= 4000) begin
      reportFailure("timeout, the run did not finish within 4000 cycles");
    end
  end

  // Bound checker raised an assertion
  always @(dut.chk.failCount) begin
    if (dut.chk.failCount != 0) begin
      reportFailure("a concurrent assertion in the checker failed");
    end
  end

  task automatic stopRun();
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic reportFailure(input string msg);
    $display("ERROR in test %s: %s", testName, msg);
    stopRun();
  endtask

  task automatic reportMismatch(input string what, input int expV, input int actV);
    $display("MISMATCH in test %s: %s expected %0d actual %0d", testName, what, expV, actV);
    stopRun();
  endtask

  function automatic int randRange(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // Any channel with a full set
  function automatic int randomChannel();
    int c;
    do begin
      c = randRange(0, numChannels - 1);
    end while (!loadedMask[c]);
    return c;
  endfunction

  // Count of thresholds not above the sample plus bias
  function automatic int expectedResult(input int c, input int v);
    int cnt;
    cnt = 0;
    for (int k = 0; k < numThresholds; k++) begin
      if (thrModel[c][k] <= v) cnt++;
    end
    return cnt + outBias;
  endfunction

  // Output present now is taken at the next edge if run is high
  task automatic checkOutput(input logic runV);
    result_t expR;
    if (out.vld && runV) begin
      if (expQ.size() == 0) begin
        reportFailure("output valid while no result was expected");
      end
      expR = expQ.pop_front();
      recvCount++;
      assert (out.cnl == expR.cnl)
        else reportMismatch("channel", int'(expR.cnl), int'(out.cnl));
      assert (out.data == expR.data)
        else reportMismatch("result", int'($signed(expR.data)), int'($signed(out.data)));
    end
  endtask

  // One clock of stimulus on the falling edge
  task automatic driveCycle(input logic runV, input sample_t smp,
                            input logic cv, input cfgCmd_t cmd);
    result_t expR;
    @(negedge clk);
    checkOutput(runV);
    run = runV;
    in = smp;
    cfgValid = cv;                      // Strobe cleared by the next call
    cfgCmd = cmd;
    if (runV && smp.vld) begin          // Ignored when run is low
      expR.vld = 1'b1;
      expR.cnl = smp.cnl;
      expR.data = resBits'(expectedResult(int'(smp.cnl), int'($signed(smp.data))));
      expQ.push_back(expR);
      sentCount++;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) driveCycle(1'b1, '0, 1'b0, '0);
  endtask

  task automatic sendCmd(input cfgOp_e op, input int c, input int v);
    cfgCmd_t cmd;
    cmd.op = op;
    cmd.cnl = cnlBits'(c);
    cmd.value = inBits'(v);
    driveCycle(1'b1, '0, 1'b1, cmd);
  endtask

  task automatic sendSample(input logic runV, input logic vldV, input int c, input int v);
    sample_t smp;
    smp.vld = vldV;
    smp.cnl = cnlBits'(c);
    smp.data = inBits'(v);
    driveCycle(runV, smp, 1'b0, '0);
  endtask

  // Last enabled input leaves after outBits enabled edges
  task automatic drain();
    idle(outBits);
    assert (recvCount == sentCount)
      else reportMismatch("result count", sentCount, recvCount);
  endtask

  // Random strictly ascending set that may start at the input minimum
  task automatic loadChannel(input int c, input logic fromMin);
    int v;
    sendCmd(opStart, c, 0);
    loadedMask[c] = 1'b0;
    v = fromMin ? -128 : randRange(-120, -100);
    for (int k = 0; k < numThresholds; k++) begin
      if (k > 0) v = v + randRange(1, 15);   // Tops out below 127
      thrModel[c][k] = v;
      sendCmd(opWrite, c, v);
      if (k == 0) begin
        assert (!cfgDone[c]) else reportFailure("cfgDone did not clear on opStart");
      end
    end
    idle(1);                            // cfgDone due one cycle after the last write
    loadedMask[c] = 1'b1;
    assert (cfgDone == loadedMask)
      else reportMismatch("cfgDone", int'(loadedMask), int'(cfgDone));
  endtask

  task automatic randomSamples(input int n);
    int c;
    for (int i = 0; i < n; i++) begin
      c = randomChannel();
      sendSample(1'b1, 1'b1, c, randRange(-128, 127));
    end
  endtask

  // Random run and valid in every cycle
  task automatic stallStream(input int n);
    logic runV;
    logic vldV;
    int c;
    for (int i = 0; i < n; i++) begin
      runV = randRange(0, 1) == 1;
      vldV = randRange(0, 3) != 0;
      c = randomChannel();
      sendSample(runV, vldV, c, randRange(-128, 127));
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    cfgValid = 1'b0;
    cfgCmd = '0;
    run = 1'b0;
    in = '0;
    seed = 32'h71f27067;
    loadedMask = '0;
    sentCount = 0;
    recvCount = 0;
    cycleCount = 0;
    testName = "reset";
    repeat (10) @(negedge clk);
    rst = 1'b0;
    assert (!out.vld && !cfgError && cfgDone == '0)
      else reportFailure("outputs were not cleared by reset");

    testName = "loadAll";
    loadChannel(0, 1'b1);               // Lowest threshold equals the minimum input
    for (int c = 1; c < numChannels; c++) begin
      loadChannel(c, 1'b0);
    end
    assert (!cfgError) else reportFailure("cfgError set by an ascending load");
    randomSamples(400);
    drain();

    testName = "edges";
    for (int c = 0; c < numChannels; c++) begin
      sendSample(1'b1, 1'b1, c, -128);
      sendSample(1'b1, 1'b1, c, 127);
      for (int k = 0; k < numThresholds; k++) begin
        sendSample(1'b1, 1'b1, c, thrModel[c][k]);        // Counts itself
        if (thrModel[c][k] > -128) begin
          sendSample(1'b1, 1'b1, c, thrModel[c][k] - 1);  // Just below
        end
      end
    end
    drain();

    testName = "stall";
    stallStream(600);
    drain();

    testName = "badOrder";
    assert (!cfgError) else reportFailure("cfgError set before any bad write");
    sendCmd(opStart, 2, 0);
    loadedMask[2] = 1'b0;
    sendCmd(opWrite, 2, 50);
    sendCmd(opWrite, 2, 40);            // Descending
    idle(1);
    assert (cfgError) else reportFailure("descending write did not set cfgError");
    assert (cfgDone == loadedMask)
      else reportMismatch("cfgDone", int'(loadedMask), int'(cfgDone));
    randomSamples(200);                 // Channels 0, 1 and 3 only
    drain();

    testName = "reload";
    loadChannel(1, 1'b0);
    randomSamples(200);
    drain();

    testName = "final";
    if (dut.chk.failCount == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      reportFailure("the checker reported assertion failures");
    end
  end

endmodule

/* verif/thresholdUnit_checker.sv */
// Concurrent checks bound into thresholdUnit
// Latency is counted in cycles with run high only
// Samples are assumed to arrive on fully loaded channels only
`timescale 1ns/1ps

module thresholdUnit_checker import thresholdPkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    run,
  input sample_t in,
  input result_t out,
  input logic    cfgError
);

  logic               seenIn;     // An enabled sample has entered
  logic [outBits-1:0] vldTrack;   // Valid bits moved on enabled cycles
  logic [outBits-1:0] maxTrack;   // Enabled samples at the input maximum
  int                 outVal;
  int                 failCount = 0;  // Watched by the testbench

  always_ff @(posedge clk) begin
    if (rst) begin
      seenIn <= 1'b0;
      vldTrack <= '0;
      maxTrack <= '0;
    end else if (run) begin
      seenIn <= seenIn || in.vld;
      vldTrack <= {vldTrack[outBits-2:0], in.vld};
      maxTrack <= {maxTrack[outBits-2:0],
                   in.vld && (in.data == {1'b0, {(inBits-1){1'b1}}})};
    end
  end

  assign outVal = int'($signed(out.data));

  // Nothing comes out before something went in
  noEarlyOut: assert property (@(posedge clk) disable iff (rst) !seenIn |-> !out.vld)
    else begin
      $error("out.vld high before any sample was accepted");
      failCount++;
    end

  // Exactly outBits enabled cycles from in.vld to out.vld
  latency: assert property (@(posedge clk) disable iff (rst) out.vld == vldTrack[outBits-1])
    else begin
      $error("out.vld does not follow in.vld after %0d enabled cycles", outBits);
      failCount++;
    end

  // The input maximum passes every threshold, top of the range
  maxResult: assert property (@(posedge clk) disable iff (rst)
    maxTrack[outBits-1] |-> out.vld && outVal == outBias + numThresholds)
    else begin
      $error("input maximum gave result %0d", outVal);
      failCount++;
    end

  // Sticky until reset
  errSticky: assert property (@(posedge clk) disable iff (rst) $past(cfgError) |-> cfgError)
    else begin
      $error("cfgError fell without reset");
      failCount++;
    end

endmodule

bind thresholdUnit thresholdUnit_checker chk (
  .clk      (clk),
  .rst      (rst),
  .run      (run),
  .in       (in),
  .out      (out),
  .cfgError (cfgError)
);
